// File: source/arrayPkg.sv
// Array memory sizing
// Widths and vector types shared by the table, the element store and the engine
package arrayPkg;

  localparam int ADDRESS_BITS = 4;                  // Bits in an array number
  localparam int INDEX_BITS   = 3;                  // Bits in an element index
  localparam int DATA_BITS    = 16;                 // Width of one element

  localparam int ARRAYS       = 2 ** ADDRESS_BITS;  // Arrays in the memory
  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;    // Elements per array

  // An array number as carried on the request and returned by alloc
  typedef logic [ADDRESS_BITS-1:0] arrayNumT;

  // An element position within one array
  typedef logic [INDEX_BITS-1:0] indexT;

  // Array size, one bit wider so a full array is representable
  typedef logic [INDEX_BITS:0] sizeT;

  // Element value and response payload
  typedef logic [DATA_BITS-1:0] dataT;

endpackage

// File: source/opPkg.sv
// Array memory encodings
// Request opcodes, response error codes and controller states
package opPkg;

  typedef enum logic [4:0] {
    opAlloc,     // Hand out an array
    opFree,      // Return an array to the free list
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opAdd,       // Returns the new value
    opAddAfter,  // Returns the old value
    opSub,
    opSubAfter,
    opOr,
    opXor,
    opAnd,
    opIndex,     // Last match position plus one
    opLess,      // Count of smaller elements
    opGreater    // Count of larger elements
  } opT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errFreed,
    errBounds,
    errFull,
    errEmpty,
    errNoMemory
  } errT;

  typedef enum logic [2:0] {
    stIdle,
    stCheck,
    stExec,
    stSearch,
    stRespond
  } engineStateT;

endpackage

// File: source/arrayTable.sv
// Array bookkeeping
// Keeps sizes, allocation flags and the LIFO free list, and checks each access
`timescale 1ns/1ps

module arrayTable
  import arrayPkg::*;
  import opPkg::*;
(
  input  logic     clock,
  input  logic     arstN,
  input  opT       opCur,
  input  arrayNumT arrayCur,
  input  indexT    indexCur,
  output errT      checkError,
  output sizeT     arraySize,
  output arrayNumT allocNum,
  input  logic     tableCommit
);

  sizeT                  sizes     [ARRAYS-1:0];  // Current size of each array
  arrayNumT              freeStack [ARRAYS-1:0];  // Freed arrays, last freed on top
  logic [ARRAYS-1:0]     allocated;               // Live arrays
  logic [ADDRESS_BITS:0] stackTop;                // Entries on the free stack
  logic [ADDRESS_BITS:0] allocCount;              // Arrays ever handed out
  logic                  stackEmpty;
  logic                  inBounds;                // Index below the current size

  assign arraySize  = sizes[arrayCur];
  assign stackEmpty = stackTop == '0;
  assign inBounds   = sizeT'(indexCur) < arraySize;

  // Reuse the most recently freed array before a fresh one
  assign allocNum = stackEmpty ? allocCount[ADDRESS_BITS-1:0]
                               : freeStack[arrayNumT'(stackTop - 1'b1)];

  always_comb begin
    checkError = errNone;
    if (opCur == opAlloc) begin
      if (stackEmpty && allocCount == (ADDRESS_BITS + 1)'(ARRAYS)) begin
        checkError = errNoMemory;
      end
    end else if ({1'b0, arrayCur} >= allocCount) begin
      checkError = errNotAllocated;
    end else if (!allocated[arrayCur]) begin
      checkError = errFreed;  // Also catches a double free
    end else begin
      case (opCur)
        opRead, opAdd, opAddAfter, opSub, opSubAfter, opOr, opXor, opAnd: begin
          if (!inBounds) checkError = errBounds;
        end
        opPush: begin
          if (arraySize == sizeT'(ARRAY_LENGTH)) checkError = errFull;
        end
        opPop: begin
          if (arraySize == '0) checkError = errEmpty;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      allocated  <= '0;
      stackTop   <= '0;
      allocCount <= '0;
    end else if (tableCommit) begin
      case (opCur)
        opAlloc: begin
          allocated[allocNum] <= 1'b1;
          if (stackEmpty) allocCount <= allocCount + 1'b1;
          else stackTop <= stackTop - 1'b1;  // Pop the free stack
        end
        opFree: begin
          allocated[arrayCur] <= 1'b0;
          stackTop            <= stackTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (tableCommit) begin
      case (opCur)
        opAlloc: sizes[allocNum] <= '0;  // New arrays start empty
        opFree:  freeStack[stackTop[ADDRESS_BITS-1:0]] <= arrayCur;
        opWrite: begin
          if (!inBounds) sizes[arrayCur] <= sizeT'(indexCur) + 1'b1;  // Grow to cover
        end
        opPush:  sizes[arrayCur] <= arraySize + 1'b1;
        opPop:   sizes[arrayCur] <= arraySize - 1'b1;
        default: ;
      endcase
    end
  end

  stackBound: assert property (@(posedge clock) disable iff (!arstN)
    stackTop <= (ADDRESS_BITS + 1)'(ARRAYS));

endmodule

// File: source/elementStore.sv
// Element storage
// Executes element accesses and in-place arithmetic, and scans an array
// one element per cycle for the index, less and greater searches
`timescale 1ns/1ps

module elementStore
  import arrayPkg::*;
  import opPkg::*;
(
  input  logic     clock,
  input  logic     arstN,
  input  opT       opCur,
  input  arrayNumT arrayCur,
  input  indexT    indexCur,
  input  dataT     dataCur,
  input  sizeT     arraySize,
  input  logic     storeStart,
  output dataT     storeData,
  output logic     searchDone
);

  dataT  memory [ARRAYS-1:0][ARRAY_LENGTH-1:0];
  dataT  element;      // Element at the request index
  dataT  combined;     // Element after the arithmetic
  indexT topPos;       // Position of the last element
  dataT  scanElement;
  sizeT  scanPos;      // Next position to compare
  dataT  scanCount;    // Running search result
  logic  scanBusy;
  logic  scanHit;
  logic  scanEnd;
  logic  isSearch;

  assign element     = memory[arrayCur][indexCur];
  assign topPos      = indexT'(arraySize - 1'b1);
  assign scanElement = memory[arrayCur][scanPos[INDEX_BITS-1:0]];
  assign scanEnd     = scanBusy && scanPos == arraySize;
  assign isSearch    = opCur inside {opIndex, opLess, opGreater};

  always_comb begin
    case (opCur)
      opAdd, opAddAfter: combined = element + dataCur;
      opSub, opSubAfter: combined = element - dataCur;
      opOr:              combined = element | dataCur;
      opXor:             combined = element ^ dataCur;
      opAnd:             combined = element & dataCur;
      default:           combined = dataCur;
    endcase
  end

  always_comb begin
    case (opCur)
      opIndex: scanHit = scanElement == dataCur;
      opLess:  scanHit = scanElement < dataCur;   // Unsigned compare
      default: scanHit = scanElement > dataCur;
    endcase
  end

  always_ff @(posedge clock) begin
    if (storeStart) begin
      case (opCur)
        opWrite: begin
          memory[arrayCur][indexCur] <= dataCur;
          storeData                  <= dataCur;
        end
        opPush: begin
          memory[arrayCur][arraySize[INDEX_BITS-1:0]] <= dataCur;  // Append at the top
          storeData                                   <= dataCur;
        end
        opRead: storeData <= element;
        opSize: storeData <= dataT'(arraySize);
        opPop:  storeData <= memory[arrayCur][topPos];
        opAdd, opSub, opOr, opXor, opAnd: begin
          memory[arrayCur][indexCur] <= combined;
          storeData                  <= combined;
        end
        opAddAfter, opSubAfter: begin
          memory[arrayCur][indexCur] <= combined;
          storeData                  <= element;  // Value before the update
        end
        default: ;
      endcase
    end else if (scanEnd) begin
      storeData <= scanCount;
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      scanBusy   <= 1'b0;
      searchDone <= 1'b0;
      scanPos    <= '0;
      scanCount  <= '0;
    end else begin
      searchDone <= 1'b0;
      if (storeStart && isSearch) begin
        scanBusy  <= 1'b1;
        scanPos   <= '0;
        scanCount <= '0;
      end else if (scanEnd) begin
        scanBusy   <= 1'b0;
        searchDone <= 1'b1;
      end else if (scanBusy) begin
        if (scanHit) begin
          // Index keeps the latest hit, the counts accumulate
          scanCount <= (opCur == opIndex) ? dataT'(scanPos) + 1'b1 : scanCount + 1'b1;
        end
        scanPos <= scanPos + 1'b1;
      end
    end
  end

  doneInSearch: assert property (@(posedge clock) disable iff (!arstN)
    searchDone |-> isSearch);

endmodule

// File: source/arrayEngine.sv
// Request controller
// Accepts one request at a time, sequences check, execute and search,
// and holds the response until the consumer takes it
`timescale 1ns/1ps

module arrayEngine
  import arrayPkg::*;
  import opPkg::*;
(
  input  logic     clock,
  input  logic     arstN,
  input  logic     reqValid,
  output logic     reqReady,
  input  opT       reqOp,
  input  arrayNumT reqArray,
  input  indexT    reqIndex,
  input  dataT     reqData,
  output logic     rspValid,
  input  logic     rspReady,
  output dataT     rspData,
  output errT      rspError,
  output opT       opCur,
  output arrayNumT arrayCur,
  output indexT    indexCur,
  output dataT     dataCur,
  input  errT      checkError,
  input  arrayNumT allocNum,
  output logic     tableCommit,
  output logic     storeStart,
  input  dataT     storeData,
  input  logic     searchDone
);

  engineStateT state;
  logic        accept;
  logic        checkPass;
  logic        isSearch;

  assign reqReady    = state == stIdle;
  assign accept      = reqValid && reqReady;
  assign checkPass   = checkError == errNone;
  assign isSearch    = opCur inside {opIndex, opLess, opGreater};
  assign tableCommit = state == stExec && checkPass;
  assign storeStart  = state == stExec && checkPass;

  always_ff @(posedge clock) begin
    if (accept) begin  // Request held for the whole transaction
      opCur    <= reqOp;
      arrayCur <= reqArray;
      indexCur <= reqIndex;
      dataCur  <= reqData;
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state    <= stIdle;
      rspValid <= 1'b0;
      rspData  <= '0;
      rspError <= errNone;
    end else begin
      case (state)
        stIdle: begin
          if (accept) state <= stCheck;
        end
        stCheck: begin
          rspError <= checkError;
          state    <= stExec;
        end
        stExec: begin
          // Alloc number must be taken before the commit moves it
          rspData <= (opCur == opAlloc && checkPass) ? dataT'(allocNum) : '0;
          state   <= (isSearch && checkPass) ? stSearch : stRespond;
        end
        stSearch: begin
          if (searchDone) state <= stRespond;
        end
        stRespond: begin
          if (!rspValid) begin
            rspValid <= 1'b1;
            if (rspError == errNone && opCur != opAlloc) rspData <= storeData;
          end else if (rspReady) begin
            rspValid <= 1'b0;
            state    <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  rspHeld: assert property (@(posedge clock) disable iff (!arstN)
    rspValid && !rspReady |=> rspValid && $stable(rspData) && $stable(rspError));

  oneInFlight: assert property (@(posedge clock) disable iff (!arstN)
    !(reqReady && rspValid));

endmodule

// File: source/arrayMemory.sv
// Managed array memory
// Request/response front end over a table of arrays and their element store
`timescale 1ns/1ps

module arrayMemory
  import arrayPkg::*;
  import opPkg::*;
(
  input  logic     clock,
  input  logic     arstN,
  input  logic     reqValid,
  output logic     reqReady,
  input  opT       reqOp,
  input  arrayNumT reqArray,
  input  indexT    reqIndex,
  input  dataT     reqData,
  output logic     rspValid,
  input  logic     rspReady,
  output dataT     rspData,
  output errT      rspError
);

  opT       opCur;
  arrayNumT arrayCur;
  indexT    indexCur;
  dataT     dataCur;
  errT      checkError;
  sizeT     arraySize;
  arrayNumT allocNum;
  logic     tableCommit;
  logic     storeStart;
  dataT     storeData;
  logic     searchDone;

  arrayEngine engine_i (
    .clock(clock), .arstN(arstN),
    .reqValid(reqValid), .reqReady(reqReady), .reqOp(reqOp),
    .reqArray(reqArray), .reqIndex(reqIndex), .reqData(reqData),
    .rspValid(rspValid), .rspReady(rspReady), .rspData(rspData), .rspError(rspError),
    .opCur(opCur), .arrayCur(arrayCur), .indexCur(indexCur), .dataCur(dataCur),
    .checkError(checkError), .allocNum(allocNum), .tableCommit(tableCommit),
    .storeStart(storeStart), .storeData(storeData), .searchDone(searchDone)
  );

  arrayTable table_i (
    .clock(clock), .arstN(arstN),
    .opCur(opCur), .arrayCur(arrayCur), .indexCur(indexCur),
    .checkError(checkError), .arraySize(arraySize), .allocNum(allocNum),
    .tableCommit(tableCommit)
  );

  elementStore store_i (
    .clock(clock), .arstN(arstN),
    .opCur(opCur), .arrayCur(arrayCur), .indexCur(indexCur), .dataCur(dataCur),
    .arraySize(arraySize), .storeStart(storeStart),
    .storeData(storeData), .searchDone(searchDone)
  );

endmodule

// File: bench/clockGen.sv
// Testbench clock and reset source
// 40 ns clock, reset held low for the first 16 rising edges
`timescale 1ns/1ps

module clockGen (
  output logic clock,
  output logic arstN
);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;  // 40 ns period
  end

  initial begin
    arstN = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    arstN <= 1'b1;  // Release away from the active edge
  end

endmodule

// File: bench/arrayMemoryTb.sv
// Testbench for the managed array memory
// Drives requests through a reference model, assertions compare every response
`timescale 1ns/1ps

module arrayMemoryTb
  import arrayPkg::*;
  import opPkg::*;
();

  localparam int CYCLE_LIMIT = 4000;  // About four times the longest test

  logic clock;
  logic arstN;
  logic reqValid;
  logic reqReady;
  opT   reqOp;
  arrayNumT reqArray;
  indexT reqIndex;
  dataT reqData;
  logic rspValid;
  logic rspReady;
  dataT rspData;
  errT  rspError;

  // Reference model state
  dataT  model [ARRAYS][ARRAY_LENGTH];
  int    sizes [ARRAYS];
  bit    live  [ARRAYS];
  int    freeList [$];  // Last freed on the back
  int    handedOut;

  errT   expError;
  dataT  expData;
  logic  expDataValid;  // Free has no defined payload
  integer seed = 32'h7b0a_1a1b;
  int    forceHold = -1;  // Negative means a random stall
  int    cycles;
  int    responses;
  int    failCount;
  int    testsPassed;
  int    testsFailed;
  int    testFailStart;
  int    testRespStart;
  string testName = "reset";
  dataT  pool [3];
  opT    arithOps [7] = '{opAdd, opAddAfter, opSub, opSubAfter, opOr, opXor, opAnd};

  clockGen clocks_i (.clock(clock), .arstN(arstN));

  arrayMemory dut_i (
    .clock(clock), .arstN(arstN),
    .reqValid(reqValid), .reqReady(reqReady), .reqOp(reqOp),
    .reqArray(reqArray), .reqIndex(reqIndex), .reqData(reqData),
    .rspValid(rspValid), .rspReady(rspReady), .rspData(rspData), .rspError(rspError)
  );

  responseMatch: assert property (@(posedge clock) disable iff (!arstN)
    rspValid && rspReady |-> rspError == expError && (!expDataValid || rspData == expData))
    else begin
      failCount++;
      $display("ERR %s: expected error %0d data %h, actual error %0d data %h", testName,
               $sampled(expError), $sampled(expData), $sampled(rspError), $sampled(rspData));
    end

  stallHold: assert property (@(posedge clock) disable iff (!arstN)
    rspValid && !rspReady |=> $stable(rspData) && $stable(rspError) && !reqReady)
    else begin
      failCount++;
      $display("In %s the held response changed or a new request was let in", testName);
    end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic dataT randomData();
    return dataT'($random(seed));
  endfunction

  // Expected response and model update for one request
  task automatic predict(input opT op, input int arr, input int idx, input dataT data);
    int num;
    int count;
    dataT old;
    dataT updated;
    expError     = errNone;
    expData      = '0;
    expDataValid = 1'b1;
    if (op == opAlloc) begin
      if (freeList.size() == 0 && handedOut == ARRAYS) expError = errNoMemory;
    end else if (arr >= handedOut) begin
      expError = errNotAllocated;
    end else if (!live[arr]) begin
      expError = errFreed;
    end else if (op inside {opRead, opAdd, opAddAfter, opSub, opSubAfter, opOr, opXor, opAnd}
                 && idx >= sizes[arr]) begin
      expError = errBounds;
    end else if (op == opPush && sizes[arr] == ARRAY_LENGTH) begin
      expError = errFull;
    end else if (op == opPop && sizes[arr] == 0) begin
      expError = errEmpty;
    end
    if (expError == errNone) begin
      case (op)
        opAlloc: begin
          if (freeList.size() > 0) begin
            num = freeList.pop_back();  // LIFO reuse
          end else begin
            num = handedOut;
            handedOut++;
          end
          live[num]  = 1'b1;
          sizes[num] = 0;
          expData    = dataT'(num);
        end
        opFree: begin
          freeList.push_back(arr);
          live[arr]    = 1'b0;
          expDataValid = 1'b0;
        end
        opWrite: begin
          model[arr][idx] = data;
          if (idx >= sizes[arr]) sizes[arr] = idx + 1;
          expData = data;
        end
        opRead:  expData = model[arr][idx];
        opSize:  expData = dataT'(sizes[arr]);
        opPush: begin
          model[arr][sizes[arr]] = data;
          sizes[arr]++;
          expData = data;
        end
        opPop: begin
          sizes[arr]--;
          expData = model[arr][sizes[arr]];
        end
        opIndex, opLess, opGreater: begin
          count = 0;
          for (int p = 0; p < sizes[arr]; p++) begin
            if (op == opIndex && model[arr][p] == data) count = p + 1;  // Last match
            else if (op == opLess && model[arr][p] < data) count++;
            else if (op == opGreater && model[arr][p] > data) count++;
          end
          expData = dataT'(count);
        end
        default: begin
          old = model[arr][idx];
          case (op)
            opAdd, opAddAfter: updated = old + data;
            opSub, opSubAfter: updated = old - data;
            opOr:              updated = old | data;
            opXor:             updated = old ^ data;
            default:           updated = old & data;
          endcase
          model[arr][idx] = updated;
          expData = (op inside {opAddAfter, opSubAfter}) ? old : updated;
        end
      endcase
    end
  endtask

  // One request and its response, with a random consumer stall
  task automatic issue(input opT op, input int arr, input int idx, input dataT data);
    int hold;
    predict(op, arr, idx, data);
    hold = (forceHold >= 0) ? forceHold : ($random(seed) & 3);
    reqValid <= 1'b1;
    reqOp    <= op;
    reqArray <= arrayNumT'(arr);
    reqIndex <= indexT'(idx);
    reqData  <= data;
    rspReady <= (hold == 0);
    do @(posedge clock); while (!reqReady);
    reqValid <= 1'b0;
    if (hold > 0) begin
      do @(posedge clock); while (!rspValid);
      repeat (hold - 1) @(posedge clock);
      rspReady <= 1'b1;
    end
    do @(posedge clock); while (!(rspValid && rspReady));
    rspReady <= 1'b0;
    responses++;
    @(posedge clock);  // Let the checks settle before the model moves on
  endtask

  task automatic startTest(input string name);
    testName      = name;
    testFailStart = failCount;
    testRespStart = responses;
  endtask

  task automatic endTest();
    int errors;
    errors = failCount - testFailStart;
    if (errors == 0) testsPassed++;
    else testsFailed++;
    $display("%-13s %0d responses, %0d errors", testName, responses - testRespStart, errors);
  endtask

  initial begin
    reqValid = 1'b0;
    reqOp    = opAlloc;
    reqArray = '0;
    reqIndex = '0;
    reqData  = '0;
    rspReady = 1'b0;
    wait (arstN === 1'b1);
    @(posedge clock);

    startTest("access");
    issue(opWrite, 3, 0, randomData());  // Never handed out
    issue(opRead, 9, 0, '0);
    issue(opAlloc, 0, 0, '0);
    issue(opWrite, 0, 4, randomData());
    issue(opSize, 0, 0, '0);
    issue(opRead, 0, 5, '0);
    issue(opRead, 0, 7, '0);
    issue(opWrite, 0, 2, randomData());
    issue(opRead, 0, 4, '0);
    issue(opRead, 0, 2, '0);
    issue(opSize, 0, 0, '0);
    endTest();

    startTest("allocation");
    repeat (3) issue(opAlloc, 0, 0, '0);
    issue(opFree, 2, 0, '0);
    issue(opFree, 3, 0, '0);
    repeat (2) issue(opAlloc, 0, 0, '0);  // Reverse order of freeing
    issue(opFree, 2, 0, '0);
    issue(opFree, 2, 0, '0);              // Double free
    repeat (16) issue(opAlloc, 0, 0, '0); // Runs out of arrays
    endTest();

    startTest("stack");
    issue(opPop, 4, 0, '0);
    repeat (9) issue(opPush, 4, 0, randomData());
    repeat (9) issue(opPop, 4, 0, '0);
    endTest();

    startTest("arithmetic");
    for (int i = 0; i < 7; i++) begin
      issue(opWrite, 5, i, randomData());
      issue(arithOps[i], 5, i, randomData());
      issue(opRead, 5, i, '0);
    end
    issue(opAnd, 5, 7, randomData());  // Past the size
    endTest();

    startTest("search");
    for (int i = 0; i < 3; i++) pool[i] = randomData();
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      issue(opWrite, 6, i, pool[$unsigned($random(seed)) % 3]);  // Repeats on purpose
    end
    for (int i = 0; i < 3; i++) begin
      issue(opIndex, 6, 0, pool[i]);
      issue(opLess, 6, 0, pool[i]);
      issue(opGreater, 6, 0, pool[i]);
    end
    issue(opIndex, 6, 0, randomData());
    issue(opLess, 5, 0, randomData());  // Seven of eight filled
    endTest();

    startTest("backpressure");
    forceHold = 3;
    issue(opRead, 0, 4, '0);
    issue(opRead, 0, 7, '0);
    issue(opGreater, 6, 0, pool[0]);
    forceHold = -1;
    endTest();

    $display("Tests passed: %0d, failed: %0d, check failures: %0d",
             testsPassed, testsFailed, failCount);
    if (testsFailed == 0 && failCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: flist.f
source/arrayPkg.sv
source/opPkg.sv
source/arrayTable.sv
source/elementStore.sv
source/arrayEngine.sv
source/arrayMemory.sv
bench/clockGen.sv
bench/arrayMemoryTb.sv
